//--- Bender.yml
package:
  name: lc3b_pipeline

sources:
  - files:
      - lc3b_types.sv
      - flow_control.sv
      - instruction_fetch.sv
      - instruction_decode.sv
      - execution_module.sv
      - memory_module.sv
      - writeback_module.sv
      - cpu_datapath.sv
  - target: simulation
    files:
      - tb_cpu_datapath.sv

//--- cpu_datapath.sv
module cpu_datapath
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input logic resp_a,
	input logic resp_b,
	input lc3b_word mem_rdata1,
	input lc3b_word mem_rdata2,
	output lc3b_word mem_addr1,
	output logic mem_read1,
	output lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_word mem_wdata2
);

// IF/ID
lc3b_word if_ir, if_pc;
// Decode sources
lc3b_reg dec_sr1_idx, dec_sr2_idx;
logic dec_sr1_valid, dec_sr2_valid;
// ID/EX
lc3b_word id_ir, id_pc, id_sr1, id_sr2, id_imm;
lc3b_reg id_dest, id_sr1_idx, id_sr2_idx;
lc3b_aluop id_aluop;
logic id_reg_write, id_is_load, id_is_store, id_is_branch, id_use_imm;
// EX/MEM
lc3b_word ex_ir, ex_alu, ex_store_data, ex_target;
lc3b_reg ex_dest;
logic ex_reg_write, ex_is_load, ex_is_store, ex_is_branch;
// MEM/WB
lc3b_word mem_ir, mem_alu, mem_mdr, mem_target;
lc3b_reg mem_dest;
logic mem_reg_write, mem_is_load, mem_is_branch;
// Writeback and control
lc3b_word wb_data, branch_target;
lc3b_reg wb_dest;
logic wb_we, branch_taken;
logic advance, bubble_ex, squash, data_wait;

flow_control flow_control (
	.clk(clk), .rst_n(rst_n), .data_wait(data_wait),
	.sr1_idx(dec_sr1_idx), .sr1_valid(dec_sr1_valid),
	.sr2_idx(dec_sr2_idx), .sr2_valid(dec_sr2_valid),
	.ex_dest(id_dest), .ex_is_load(id_is_load), .branch_taken(branch_taken),
	.advance(advance), .bubble_ex(bubble_ex), .squash(squash)
);

instruction_fetch if_stage (
	.clk(clk), .rst_n(rst_n), .resp_a(resp_a), .mem_rdata1(mem_rdata1),
	.advance(advance), .hold(bubble_ex), .branch_taken(branch_taken),
	.branch_target(branch_target), .squash(squash),
	.mem_addr1(mem_addr1), .mem_read1(mem_read1), .if_ir(if_ir), .if_pc(if_pc)
);

instruction_decode id_stage (
	.clk(clk), .rst_n(rst_n), .if_ir(if_ir), .if_pc(if_pc),
	.advance(advance), .bubble_ex(bubble_ex), .squash(squash),
	.wb_we(wb_we), .wb_dest(wb_dest), .wb_data(wb_data),
	.dec_sr1_idx(dec_sr1_idx), .dec_sr2_idx(dec_sr2_idx),
	.dec_sr1_valid(dec_sr1_valid), .dec_sr2_valid(dec_sr2_valid),
	.id_ir(id_ir), .id_pc(id_pc), .id_dest(id_dest), .id_reg_write(id_reg_write),
	.id_aluop(id_aluop), .id_is_load(id_is_load), .id_is_store(id_is_store),
	.id_is_branch(id_is_branch), .id_sr1(id_sr1), .id_sr2(id_sr2),
	.id_sr1_idx(id_sr1_idx), .id_sr2_idx(id_sr2_idx),
	.id_imm(id_imm), .id_use_imm(id_use_imm)
);

execution_module ex_stage (
	.clk(clk), .rst_n(rst_n), .id_ir(id_ir), .id_pc(id_pc), .id_dest(id_dest),
	.id_reg_write(id_reg_write), .id_aluop(id_aluop), .id_is_load(id_is_load),
	.id_is_store(id_is_store), .id_is_branch(id_is_branch),
	.id_sr1(id_sr1), .id_sr2(id_sr2), .id_sr1_idx(id_sr1_idx), .id_sr2_idx(id_sr2_idx),
	.id_imm(id_imm), .id_use_imm(id_use_imm), .advance(advance), .squash(squash),
	.fwd_mem_dest(ex_dest), .fwd_mem_data(ex_alu), .fwd_mem_we(ex_reg_write),
	.fwd_wb_dest(wb_dest), .fwd_wb_data(wb_data), .fwd_wb_we(wb_we),
	.ex_ir(ex_ir), .ex_dest(ex_dest), .ex_reg_write(ex_reg_write),
	.ex_is_load(ex_is_load), .ex_is_store(ex_is_store), .ex_is_branch(ex_is_branch),
	.ex_alu(ex_alu), .ex_store_data(ex_store_data), .branch_target(ex_target)
);

memory_module mem_stage (
	.clk(clk), .rst_n(rst_n), .ex_ir(ex_ir), .ex_dest(ex_dest),
	.ex_reg_write(ex_reg_write), .ex_is_load(ex_is_load), .ex_is_store(ex_is_store),
	.ex_is_branch(ex_is_branch), .ex_alu(ex_alu), .ex_store_data(ex_store_data),
	.ex_target(ex_target), .resp_b(resp_b), .mem_rdata2(mem_rdata2),
	.advance(advance), .squash(squash),
	.mem_addr2(mem_addr2), .mem_read2(mem_read2), .mem_write2(mem_write2),
	.mem_wdata2(mem_wdata2), .data_wait(data_wait),
	.mem_ir(mem_ir), .mem_dest(mem_dest), .mem_reg_write(mem_reg_write),
	.mem_is_load(mem_is_load), .mem_is_branch(mem_is_branch),
	.mem_alu(mem_alu), .mem_mdr(mem_mdr), .mem_target(mem_target)
);

writeback_module wb_stage (
	.clk(clk), .rst_n(rst_n), .mem_ir(mem_ir), .mem_dest(mem_dest),
	.mem_reg_write(mem_reg_write), .mem_is_load(mem_is_load),
	.mem_is_branch(mem_is_branch), .mem_alu(mem_alu), .mem_mdr(mem_mdr),
	.mem_target(mem_target),
	.wb_we(wb_we), .wb_dest(wb_dest), .wb_data(wb_data),
	.branch_taken(branch_taken), .branch_target(branch_target)
);

endmodule : cpu_datapath

//--- execution_module.sv
module execution_module
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input lc3b_word id_ir,
	input lc3b_word id_pc,
	input lc3b_reg id_dest,
	input logic id_reg_write,
	input lc3b_aluop id_aluop,
	input logic id_is_load,
	input logic id_is_store,
	input logic id_is_branch,
	input lc3b_word id_sr1,
	input lc3b_word id_sr2,
	input lc3b_reg id_sr1_idx,
	input lc3b_reg id_sr2_idx,
	input lc3b_word id_imm,
	input logic id_use_imm,
	input logic advance,
	input logic squash,
	input lc3b_reg fwd_mem_dest,
	input lc3b_word fwd_mem_data,
	input logic fwd_mem_we,
	input lc3b_reg fwd_wb_dest,
	input lc3b_word fwd_wb_data,
	input logic fwd_wb_we,
	output lc3b_word ex_ir,
	output lc3b_reg ex_dest,
	output logic ex_reg_write,
	output logic ex_is_load,
	output logic ex_is_store,
	output logic ex_is_branch,
	output lc3b_word ex_alu,
	output lc3b_word ex_store_data,
	output lc3b_word branch_target
);

lc3b_word op_a, op_b_reg, op_b, alu_out, target;

// Youngest producer wins
function automatic lc3b_word fwd_sel(input lc3b_reg idx, input lc3b_word rf_val,
	input logic m_we, input lc3b_reg m_dest, input lc3b_word m_data,
	input logic w_we, input lc3b_reg w_dest, input lc3b_word w_data);
	if (m_we && m_dest == idx) begin
		return m_data;
	end
	if (w_we && w_dest == idx) begin
		return w_data;
	end
	return rf_val;
endfunction

assign op_a = fwd_sel(id_sr1_idx, id_sr1, fwd_mem_we, fwd_mem_dest, fwd_mem_data,
	fwd_wb_we, fwd_wb_dest, fwd_wb_data);
assign op_b_reg = fwd_sel(id_sr2_idx, id_sr2, fwd_mem_we, fwd_mem_dest, fwd_mem_data,
	fwd_wb_we, fwd_wb_dest, fwd_wb_data);
assign op_b = id_use_imm ? id_imm : op_b_reg;
assign target = id_pc + PC_STEP + (id_imm << 1); // Word offset9 from next PC

always_comb begin
	case (id_aluop)
		alu_add: alu_out = op_a + op_b;
		alu_and: alu_out = op_a & op_b;
		alu_not: alu_out = ~op_a;
		default: alu_out = op_b;
	endcase
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		ex_ir <= NOP_IR;
		ex_dest <= '0;
		ex_reg_write <= 1'b0;
		ex_is_load <= 1'b0;
		ex_is_store <= 1'b0;
		ex_is_branch <= 1'b0;
	end else if (squash) begin
		ex_ir <= NOP_IR;
		ex_reg_write <= 1'b0;
		ex_is_load <= 1'b0;
		ex_is_store <= 1'b0;
		ex_is_branch <= 1'b0;
	end else if (advance) begin
		ex_ir <= id_ir;
		ex_dest <= id_dest;
		ex_reg_write <= id_reg_write;
		ex_is_load <= id_is_load;
		ex_is_store <= id_is_store;
		ex_is_branch <= id_is_branch;
	end
end

always_ff @(posedge clk) begin
	if (advance) begin
		ex_alu <= alu_out;
		ex_store_data <= op_b_reg;
		branch_target <= target;
	end
end

endmodule : execution_module

//--- flow_control.sv
module flow_control
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input logic data_wait,
	input lc3b_reg sr1_idx,
	input logic sr1_valid,
	input lc3b_reg sr2_idx,
	input logic sr2_valid,
	input lc3b_reg ex_dest,
	input logic ex_is_load,
	input logic branch_taken,
	output logic advance,
	output logic bubble_ex,
	output logic squash
);

logic squash_q;
logic sr1_hit;
logic sr2_hit;

assign advance = !data_wait; // Whole pipeline freezes on a pending data access

assign sr1_hit = sr1_valid && (sr1_idx == ex_dest);
assign sr2_hit = sr2_valid && (sr2_idx == ex_dest);
assign bubble_ex = ex_is_load && (sr1_hit || sr2_hit); // Load data exists only after MEM

// Redirect pulse, one cycle per taken branch
assign squash = branch_taken && !squash_q;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		squash_q <= 1'b0;
	end else begin
		squash_q <= squash;
	end
end

endmodule : flow_control

//--- instruction_decode.sv
module instruction_decode
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input lc3b_word if_ir,
	input lc3b_word if_pc,
	input logic advance,
	input logic bubble_ex,
	input logic squash,
	input logic wb_we,
	input lc3b_reg wb_dest,
	input lc3b_word wb_data,
	output lc3b_reg dec_sr1_idx,
	output lc3b_reg dec_sr2_idx,
	output logic dec_sr1_valid,
	output logic dec_sr2_valid,
	output lc3b_word id_ir,
	output lc3b_word id_pc,
	output lc3b_reg id_dest,
	output logic id_reg_write,
	output lc3b_aluop id_aluop,
	output logic id_is_load,
	output logic id_is_store,
	output logic id_is_branch,
	output lc3b_word id_sr1,
	output lc3b_word id_sr2,
	output lc3b_reg id_sr1_idx,
	output lc3b_reg id_sr2_idx,
	output lc3b_word id_imm,
	output logic id_use_imm
);

lc3b_word regs [8];
lc3b_opcode opcode;
lc3b_aluop aluop;
lc3b_word rf_a, rf_b, imm;
logic reg_write, is_load, is_store, is_branch, use_imm;

assign opcode = lc3b_opcode'(if_ir[15:12]);
assign dec_sr1_idx = if_ir[8:6];
assign dec_sr2_idx = (opcode == op_str) ? if_ir[11:9] : if_ir[2:0]; // STR data in SR field

always_comb begin
	reg_write = 1'b0;
	aluop = alu_pass;
	is_load = 1'b0;
	is_store = 1'b0;
	is_branch = 1'b0;
	use_imm = 1'b1;
	dec_sr1_valid = 1'b0;
	dec_sr2_valid = 1'b0;
	imm = {{7{if_ir[8]}}, if_ir[8:0]}; // offset9
	case (opcode)
		op_add, op_and: begin
			reg_write = 1'b1;
			aluop = (opcode == op_and) ? alu_and : alu_add;
			use_imm = if_ir[5];
			dec_sr1_valid = 1'b1;
			dec_sr2_valid = !if_ir[5];
			imm = {{11{if_ir[4]}}, if_ir[4:0]}; // imm5
		end
		op_not: begin
			reg_write = 1'b1;
			aluop = alu_not;
			dec_sr1_valid = 1'b1;
		end
		op_ldr, op_str: begin
			reg_write = (opcode == op_ldr);
			is_load = (opcode == op_ldr);
			is_store = (opcode == op_str);
			aluop = alu_add; // Base plus offset6
			dec_sr1_valid = 1'b1;
			dec_sr2_valid = (opcode == op_str);
			imm = {{10{if_ir[5]}}, if_ir[5:0]};
		end
		op_br: is_branch = 1'b1;
		default: ; // Unsupported opcodes behave as NOP
	endcase
end

// Same-cycle writeback is visible to decode
assign rf_a = (wb_we && wb_dest == dec_sr1_idx) ? wb_data : regs[dec_sr1_idx];
assign rf_b = (wb_we && wb_dest == dec_sr2_idx) ? wb_data : regs[dec_sr2_idx];

always_ff @(posedge clk) begin
	if (wb_we) begin
		regs[wb_dest] <= wb_data;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		id_ir <= NOP_IR;
		id_dest <= '0;
		id_reg_write <= 1'b0;
		id_aluop <= alu_pass;
		id_is_load <= 1'b0;
		id_is_store <= 1'b0;
		id_is_branch <= 1'b0;
		id_sr1_idx <= '0;
		id_sr2_idx <= '0;
		id_use_imm <= 1'b0;
	end else if (squash || (advance && bubble_ex)) begin
		id_ir <= NOP_IR;
		id_reg_write <= 1'b0;
		id_aluop <= alu_pass;
		id_is_load <= 1'b0;
		id_is_store <= 1'b0;
		id_is_branch <= 1'b0;
	end else if (advance) begin
		id_ir <= if_ir;
		id_dest <= if_ir[11:9];
		id_reg_write <= reg_write;
		id_aluop <= aluop;
		id_is_load <= is_load;
		id_is_store <= is_store;
		id_is_branch <= is_branch;
		id_sr1_idx <= dec_sr1_idx;
		id_sr2_idx <= dec_sr2_idx;
		id_use_imm <= use_imm;
	end
end

always_ff @(posedge clk) begin
	if (advance) begin
		id_pc <= if_pc;
		id_sr1 <= rf_a;
		id_sr2 <= rf_b;
		id_imm <= imm;
	end
end

endmodule : instruction_decode

//--- instruction_fetch.sv
module instruction_fetch
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input logic resp_a,
	input lc3b_word mem_rdata1,
	input logic advance,
	input logic hold,
	input logic branch_taken,
	input lc3b_word branch_target,
	input logic squash,
	output lc3b_word mem_addr1,
	output logic mem_read1,
	output lc3b_word if_ir,
	output lc3b_word if_pc
);

lc3b_word pc;
lc3b_word redirect_pc;
logic stale; // Outstanding fetch belongs to the old path
logic accept;

assign mem_addr1 = pc;
assign accept = resp_a && !stale && !branch_taken && advance && !hold;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pc <= RESET_PC;
		stale <= 1'b0;
		mem_read1 <= 1'b0;
	end else begin
		mem_read1 <= 1'b1;
		if (branch_taken) begin
			if (resp_a) begin
				pc <= branch_target; // Port is free, switch at once
				stale <= 1'b0;
			end else begin
				stale <= 1'b1;
			end
		end else if (resp_a) begin
			if (stale) begin
				pc <= redirect_pc;
				stale <= 1'b0;
			end else if (accept) begin
				pc <= pc + PC_STEP;
			end
		end
	end
end

always_ff @(posedge clk) begin
	if (branch_taken) begin
		redirect_pc <= branch_target;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		if_ir <= NOP_IR;
	end else if (squash) begin
		if_ir <= NOP_IR;
	end else if (advance && !hold) begin
		if_ir <= accept ? mem_rdata1 : NOP_IR; // Empty slot while fetch waits
	end
end

always_ff @(posedge clk) begin
	if (accept) begin
		if_pc <= pc;
	end
end

endmodule : instruction_fetch

//--- lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

// LC-3b opcode field, only the supported subset
typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_ldr = 4'b0110,
	op_str = 4'b0111,
	op_not = 4'b1001
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} lc3b_aluop;

localparam lc3b_word NOP_IR = 16'h0000; // BR with empty nzp, never taken
localparam lc3b_word RESET_PC = 16'h0000;
localparam lc3b_word PC_STEP = 16'd2; // One 16-bit instruction
localparam lc3b_nzp CC_RESET = 3'b010; // Z set

endpackage : lc3b_types

//--- memory_module.sv
module memory_module
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input lc3b_word ex_ir,
	input lc3b_reg ex_dest,
	input logic ex_reg_write,
	input logic ex_is_load,
	input logic ex_is_store,
	input logic ex_is_branch,
	input lc3b_word ex_alu,
	input lc3b_word ex_store_data,
	input lc3b_word ex_target,
	input logic resp_b,
	input lc3b_word mem_rdata2,
	input logic advance,
	input logic squash,
	output lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_word mem_wdata2,
	output logic data_wait,
	output lc3b_word mem_ir,
	output lc3b_reg mem_dest,
	output logic mem_reg_write,
	output logic mem_is_load,
	output logic mem_is_branch,
	output lc3b_word mem_alu,
	output lc3b_word mem_mdr,
	output lc3b_word mem_target
);

assign mem_addr2 = ex_alu;
assign mem_wdata2 = ex_store_data;
assign mem_read2 = ex_is_load && !squash; // Wrong-path access never starts
assign mem_write2 = ex_is_store && !squash;
assign data_wait = (mem_read2 || mem_write2) && !resp_b;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		mem_ir <= NOP_IR;
		mem_dest <= '0;
		mem_reg_write <= 1'b0;
		mem_is_load <= 1'b0;
		mem_is_branch <= 1'b0;
	end else if (squash) begin
		mem_ir <= NOP_IR;
		mem_reg_write <= 1'b0;
		mem_is_load <= 1'b0;
		mem_is_branch <= 1'b0;
	end else if (advance) begin
		mem_ir <= ex_ir;
		mem_dest <= ex_dest;
		mem_reg_write <= ex_reg_write;
		mem_is_load <= ex_is_load;
		mem_is_branch <= ex_is_branch;
	end
end

always_ff @(posedge clk) begin
	if (advance) begin
		mem_alu <= ex_alu;
		mem_target <= ex_target;
		if (ex_is_load) begin
			mem_mdr <= mem_rdata2; // resp_b is high whenever a load advances
		end
	end
end

endmodule : memory_module

//--- tb_cpu_datapath.sv
module tb_cpu_datapath
	import lc3b_types::*;
();

localparam int CLK_PERIOD = 4;
localparam int RESET_CYCLES = 10;
localparam int DRIVE_DELAY = 1;
localparam int SEED = 70540;
localparam int PROG_LEN = 200;
localparam int FINAL_IDX = PROG_LEN - 1;
localparam lc3b_word FINAL_PC = lc3b_word'(FINAL_IDX * 2);
localparam int CYCLES_PER_INSTR = 40;
localparam int TIMEOUT_CYCLES = RESET_CYCLES + PROG_LEN * CYCLES_PER_INSTR;
localparam int DRAIN_CYCLES = 40;
localparam lc3b_reg BASE_REG = 3'd7; // Never a destination, so loads and stores overlap

logic clk = 1'b0;
logic rst_n;
logic resp_a;
logic resp_b;
lc3b_word mem_rdata1;
lc3b_word mem_rdata2;
lc3b_word mem_addr1;
lc3b_word mem_addr2;
lc3b_word mem_wdata2;
logic mem_read1;
logic mem_read2;
logic mem_write2;

lc3b_word prog [PROG_LEN];
lc3b_word ref_dmem [65536];
lc3b_word dut_dmem [65536];
lc3b_word exp_store_addr [$];
lc3b_word exp_store_data [$];
lc3b_word exp_load_addr [$];
int err_count = 0;
logic reached_end = 1'b0;

logic ibusy = 1'b0;
int idelay;
lc3b_word iaddr;
logic dbusy = 1'b0;
logic dwrite;
int ddelay;
lc3b_word daddr;
lc3b_word dwdata;

cpu_datapath DUT (
	.clk(clk), .rst_n(rst_n), .resp_a(resp_a), .resp_b(resp_b),
	.mem_rdata1(mem_rdata1), .mem_rdata2(mem_rdata2),
	.mem_addr1(mem_addr1), .mem_read1(mem_read1),
	.mem_addr2(mem_addr2), .mem_read2(mem_read2), .mem_write2(mem_write2),
	.mem_wdata2(mem_wdata2)
);

always #(CLK_PERIOD / 2) clk = ~clk;

task automatic stop_with_error(input string what);
	err_count++;
	$display("%s", what);
	$display("Test FAILED");
	$fatal;
endtask

task automatic check_value(input string name, input lc3b_word expected, input lc3b_word actual);
	if (actual !== expected) begin
		err_count++;
		$display("ERR %s expected %h actual %h", name, expected, actual);
		$display("Test FAILED");
		$fatal;
	end
endtask

function automatic lc3b_word fill_word(input lc3b_word addr);
	return (addr * 16'h9e37) ^ 16'h5a5a; // Odd multiplier, every address bit counts
endfunction

function automatic lc3b_word sext(input lc3b_word v, input int bits);
	lc3b_word m;
	m = 16'hffff << bits;
	return v[bits - 1] ? (v | m) : (v & ~m);
endfunction

function automatic lc3b_nzp cc_of(input lc3b_word v);
	if (v[15]) begin
		return 3'b100;
	end
	if (v == '0) begin
		return 3'b010;
	end
	return 3'b001;
endfunction

function automatic lc3b_reg pick_base();
	return ($urandom % 4 != 0) ? BASE_REG : lc3b_reg'($urandom);
endfunction

function automatic lc3b_word imem_word(input lc3b_word addr);
	if (addr[15:1] < PROG_LEN) begin
		return prog[addr[15:1]];
	end
	return NOP_IR;
endfunction

task automatic build_program();
	int kind;
	int skip;
	lc3b_reg dr;
	lc3b_reg sa;
	lc3b_reg sb;
	for (int r = 0; r < 8; r++) begin
		prog[2 * r] = {op_and, lc3b_reg'(r), lc3b_reg'(r), 1'b1, 5'b00000};
		prog[2 * r + 1] = {op_add, lc3b_reg'(r), lc3b_reg'(r), 1'b1, 5'($urandom)};
	end
	for (int i = 16; i < FINAL_IDX; i++) begin
		kind = $urandom % 8;
		dr = lc3b_reg'($urandom % 7);
		sa = lc3b_reg'($urandom);
		sb = lc3b_reg'($urandom);
		case (kind)
			0: prog[i] = {op_add, dr, sa, 3'b000, sb};
			1: prog[i] = {op_add, dr, sa, 1'b1, 5'($urandom)};
			2: prog[i] = {op_and, dr, sa, 3'b000, sb};
			3: prog[i] = {op_and, dr, sa, 1'b1, 5'($urandom)};
			4: prog[i] = {op_not, dr, sa, 6'b111111};
			5: prog[i] = {op_ldr, dr, pick_base(), 6'($urandom)};
			6: prog[i] = {op_str, sb, pick_base(), 6'($urandom)};
			default: begin
				skip = $urandom % 5; // Forward only
				if (i + 1 + skip > FINAL_IDX) begin
					skip = FINAL_IDX - i - 1;
				end
				prog[i] = {op_br, lc3b_nzp'($urandom), 9'(skip)};
			end
		endcase
	end
	prog[FINAL_IDX] = {op_br, 3'b111, 9'h1ff}; // Branch to itself
endtask

task automatic run_reference_model();
	lc3b_word regs [8];
	lc3b_word ir;
	lc3b_word result;
	lc3b_word addr;
	lc3b_word b_val;
	lc3b_nzp cc;
	lc3b_opcode opc;
	int idx;
	logic writes;
	cc = 3'b010;
	idx = 0;
	for (int r = 0; r < 8; r++) begin
		regs[r] = '0;
	end
	while (idx != FINAL_IDX) begin
		ir = prog[idx];
		opc = lc3b_opcode'(ir[15:12]);
		idx++;
		writes = 1'b1;
		result = '0;
		b_val = ir[5] ? sext(ir, 5) : regs[ir[2:0]];
		addr = regs[ir[8:6]] + sext(ir, 6);
		case (opc)
			op_add: result = regs[ir[8:6]] + b_val;
			op_and: result = regs[ir[8:6]] & b_val;
			op_not: result = ~regs[ir[8:6]];
			op_ldr: begin
				exp_load_addr.push_back(addr);
				result = ref_dmem[addr];
			end
			op_str: begin
				exp_store_addr.push_back(addr);
				exp_store_data.push_back(regs[ir[11:9]]);
				ref_dmem[addr] = regs[ir[11:9]];
				writes = 1'b0;
			end
			default: begin
				writes = 1'b0;
				if ((ir[11:9] & cc) != 3'b000) begin
					idx = idx + int'(ir[8:0]); // Target is PC + 2 + 2 * offset
				end
			end
		endcase
		if (writes) begin
			regs[ir[11:9]] = result;
			cc = cc_of(result);
		end
	end
endtask

task automatic match_data_access();
	if (mem_write2) begin
		if (exp_store_addr.size() == 0) begin
			stop_with_error("DUT wrote data memory after the last store of the program");
		end else begin
			check_value("mem_addr2", exp_store_addr.pop_front(), mem_addr2);
			check_value("mem_wdata2", exp_store_data.pop_front(), mem_wdata2);
		end
	end else if (exp_load_addr.size() == 0) begin
		stop_with_error("DUT read data memory after the last load of the program");
	end else begin
		check_value("mem_addr2", exp_load_addr.pop_front(), mem_addr2);
	end
endtask

// Instruction memory, 0 to 3 cycles per fetch
always @(posedge clk) begin
	#DRIVE_DELAY;
	if (resp_a) begin
		resp_a = 1'b0;
		ibusy = 1'b0;
	end
	if (ibusy) begin
		check_value("mem_read1", 16'd1, 16'(mem_read1));
		check_value("mem_addr1", iaddr, mem_addr1);
	end else if (mem_read1) begin
		ibusy = 1'b1;
		iaddr = mem_addr1;
		idelay = $urandom % 4;
	end
	if (ibusy) begin
		if (idelay == 0) begin
			resp_a = 1'b1;
			mem_rdata1 = imem_word(iaddr);
			if (iaddr == FINAL_PC) begin
				reached_end = 1'b1;
			end
		end else begin
			idelay--;
		end
	end
end

// Data memory, 0 to 3 cycles per access
always @(posedge clk) begin
	#DRIVE_DELAY;
	if (resp_b) begin
		resp_b = 1'b0;
		dbusy = 1'b0;
	end
	if (dbusy) begin
		if (dwrite) begin
			check_value("mem_write2", 16'd1, 16'(mem_write2));
			check_value("mem_wdata2", dwdata, mem_wdata2);
		end else begin
			check_value("mem_read2", 16'd1, 16'(mem_read2));
		end
		check_value("mem_addr2", daddr, mem_addr2);
	end else if (mem_write2 || mem_read2) begin
		dbusy = 1'b1;
		dwrite = mem_write2;
		daddr = mem_addr2;
		dwdata = mem_wdata2;
		ddelay = $urandom % 4;
		match_data_access();
	end
	if (dbusy) begin
		if (ddelay == 0) begin
			resp_b = 1'b1;
			if (dwrite) begin
				dut_dmem[daddr] = dwdata;
			end else begin
				mem_rdata2 = dut_dmem[daddr];
			end
		end else begin
			ddelay--;
		end
	end
end

initial begin : watchdog
	#(TIMEOUT_CYCLES * CLK_PERIOD);
	stop_with_error("Timeout: the program never reached its final instruction");
end

initial begin : main_sequence
	void'($urandom(SEED));
	rst_n = 1'b0;
	resp_a = 1'b0;
	resp_b = 1'b0;
	mem_rdata1 = '0;
	mem_rdata2 = '0;
	for (int a = 0; a < 65536; a++) begin
		ref_dmem[a] = fill_word(lc3b_word'(a));
		dut_dmem[a] = fill_word(lc3b_word'(a));
	end
	build_program();
	run_reference_model();
	$display("Program has %0d stores and %0d loads on its path",
		exp_store_addr.size(), exp_load_addr.size());
	repeat (RESET_CYCLES) @(posedge clk);
	#DRIVE_DELAY;
	rst_n = 1'b1;
	check_value("mem_read2", 16'd0, 16'(mem_read2));
	check_value("mem_write2", 16'd0, 16'(mem_write2));
	check_value("mem_addr1", RESET_PC, mem_addr1);
	@(posedge clk);
	#DRIVE_DELAY;
	check_value("mem_read1", 16'd1, 16'(mem_read1));
	check_value("mem_addr1", RESET_PC, mem_addr1);
	while (!(reached_end && !dbusy && exp_store_addr.size() == 0
		&& exp_load_addr.size() == 0)) begin
		@(posedge clk);
	end
	repeat (DRAIN_CYCLES) @(posedge clk); // A late access would find empty lists
	if (err_count == 0) begin
		$display("Test OK");
	end else begin
		$display("Test FAILED");
	end
	$finish;
end

endmodule : tb_cpu_datapath

//--- vlog.f
lc3b_types.sv
flow_control.sv
instruction_fetch.sv
instruction_decode.sv
execution_module.sv
memory_module.sv
writeback_module.sv
cpu_datapath.sv
tb_cpu_datapath.sv

//--- writeback_module.sv
module writeback_module
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input lc3b_word mem_ir,
	input lc3b_reg mem_dest,
	input logic mem_reg_write,
	input logic mem_is_load,
	input logic mem_is_branch,
	input lc3b_word mem_alu,
	input lc3b_word mem_mdr,
	input lc3b_word mem_target,
	output logic wb_we,
	output lc3b_reg wb_dest,
	output lc3b_word wb_data,
	output logic branch_taken,
	output lc3b_word branch_target
);

lc3b_nzp nzp;
lc3b_nzp nzp_next;

assign wb_we = mem_reg_write;
assign wb_dest = mem_dest;
assign wb_data = mem_is_load ? mem_mdr : mem_alu;
assign branch_target = mem_target;
assign branch_taken = mem_is_branch && |(mem_ir[11:9] & nzp);

always_comb begin
	if (wb_data[15]) begin
		nzp_next = 3'b100;
	end else if (wb_data == '0) begin
		nzp_next = 3'b010;
	end else begin
		nzp_next = 3'b001;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		nzp <= CC_RESET;
	end else if (wb_we) begin
		nzp <= nzp_next; // Every register write sets the codes
	end
end

endmodule : writeback_module
